//--- dcache.f
hw/dcache_pkg.sv
hw/burst_counter.sv
hw/tag_store.sv
hw/line_store.sv
hw/dcache_ctrl.sv
hw/dcache.sv
tests/cbus_mem_model.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

//--- hw/burst_counter.sv
module burst_counter (
	input logic clk,
	input logic reset,
	input logic step,
	output dcache_pkg::beat_t beat
);
	import dcache_pkg::*;

	beat_t beat_next;

	// one count per accepted beat
	// wraps after the last word of a line, so every burst starts at 0
	always_comb begin
		beat_next = beat;
		if (step) begin
			if (beat == beat_t'(WORDS_PER_LINE - 1)) begin
				beat_next = '0;
			end else begin
				beat_next = beat + beat_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else begin
			beat <= beat_next;
		end
	end

endmodule

//--- hw/dcache.sv
module dcache (
	input logic clk,
	input logic reset,
	input dcache_pkg::dbus_req_t dreq,
	output dcache_pkg::dbus_resp_t dresp,
	output dcache_pkg::cbus_req_t creq,
	input dcache_pkg::cbus_resp_t cresp
);
	import dcache_pkg::*;

	// address fields of the cpu request
	index_t index;
	tag_t lookup_tag;

	// tag store results
	logic hit;
	line_meta_t victim;

	// burst beat
	logic step;
	beat_t beat;

	// metadata updates
	logic fill;
	logic mark_dirty;

	// line store port
	beat_t word_sel;
	strobe_t wen;
	word_t wdata;
	word_t rdata;

	// tag above index, index above line offset
	assign index = dreq.addr[OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag = dreq.addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];

	dcache_ctrl ctrl_inst (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.cresp(cresp),
		.hit(hit),
		.victim(victim),
		.beat(beat),
		.rdata(rdata),
		.step(step),
		.fill(fill),
		.mark_dirty(mark_dirty),
		.word_sel(word_sel),
		.wen(wen),
		.wdata(wdata),
		.creq(creq),
		.dresp(dresp)
	);

	// shared by writeback and fill bursts
	burst_counter counter_inst (
		.clk(clk),
		.reset(reset),
		.step(step),
		.beat(beat)
	);

	tag_store tags_inst (
		.clk(clk),
		.reset(reset),
		.index(index),
		.lookup_tag(lookup_tag),
		.fill(fill),
		.mark_dirty(mark_dirty),
		.hit(hit),
		.victim(victim)
	);

	// data array, word picked by the controller
	line_store data_inst (
		.clk(clk),
		.index(index),
		.word_sel(word_sel),
		.wen(wen),
		.wdata(wdata),
		.rdata(rdata)
	);

endmodule

//--- hw/dcache_ctrl.sv
module dcache_ctrl (
	input logic clk,
	input logic reset,
	input dcache_pkg::dbus_req_t dreq,
	input dcache_pkg::cbus_resp_t cresp,
	input logic hit,
	input dcache_pkg::line_meta_t victim,
	input dcache_pkg::beat_t beat,
	input dcache_pkg::word_t rdata,
	output logic step,
	output logic fill,
	output logic mark_dirty,
	output dcache_pkg::beat_t word_sel,
	output dcache_pkg::strobe_t wen,
	output dcache_pkg::word_t wdata,
	output dcache_pkg::cbus_req_t creq,
	output dcache_pkg::dbus_resp_t dresp
);
	import dcache_pkg::*;

	cache_state_t state;
	cache_state_t state_next;

	logic uncached;
	logic is_write;
	index_t req_index;
	addr_t fill_addr;
	addr_t victim_addr;

	// anything outside 0x8xxxxxxx bypasses the cache
	assign uncached = dreq.addr[ADDR_BITS-1 -: 4] != CACHED_REGION;
	assign is_write = |dreq.strobe;
	assign req_index = dreq.addr[OFFSET_BITS +: INDEX_BITS];

	// line-aligned request address for the fill burst
	assign fill_addr = {dreq.addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	// victim rebuilt from its stored tag, same index
	assign victim_addr = {CACHED_REGION, victim.tag, req_index, {OFFSET_BITS{1'b0}}};

	always_comb begin
		state_next = state;
		step = 1'b0;
		fill = 1'b0;
		mark_dirty = 1'b0;
		wen = '0;
		// cpu data unless a fill beat is landing
		wdata = dreq.data;
		// burst beat by default, idle uses the request word
		word_sel = beat;
		dresp.data_ok = 1'b0;
		dresp.data = rdata;

		unique case (state)
			S_IDLE: begin
				word_sel = dreq.addr[ALIGN_BITS +: WORD_BITS];
				if (dreq.valid) begin
					if (uncached) begin
						state_next = S_UNCACHED;
					end else if (hit) begin
						// hit completes now, write commits at this edge
						dresp.data_ok = 1'b1;
						wen = dreq.strobe;
						mark_dirty = is_write;
					end else if (victim.valid && victim.dirty) begin
						state_next = S_WRITEBACK;
					end else begin
						state_next = S_FILL;
					end
				end
			end
			S_WRITEBACK: begin
				// creq.data follows rdata at the current beat
				if (cresp.ready) begin
					step = 1'b1;
					if (cresp.last) begin
						state_next = S_FILL;
					end
				end
			end
			S_FILL: begin
				wdata = cresp.data;
				if (cresp.ready) begin
					step = 1'b1;
					wen = '1;
					if (cresp.last) begin
						// tag valid from next cycle, request then hits
						fill = 1'b1;
						state_next = S_IDLE;
					end
				end
			end
			S_UNCACHED: begin
				dresp.data = cresp.data;
				if (cresp.ready) begin
					dresp.data_ok = 1'b1;
					state_next = S_IDLE;
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	// memory request, fields stay put for the whole state
	always_comb begin
		creq = '0;
		creq.valid = state != S_IDLE;
		creq.size = MSIZE8;
		creq.strobe = '1;
		creq.len_last = beat_t'(WORDS_PER_LINE - 1);
		creq.burst = BURST_INCR;
		creq.data = rdata;
		creq.addr = fill_addr;
		unique case (state)
			S_WRITEBACK: begin
				creq.is_write = 1'b1;
				creq.addr = victim_addr;
			end
			S_UNCACHED: begin
				// single beat, passes the cpu request through
				creq.is_write = is_write;
				creq.addr = dreq.addr;
				creq.size = dreq.size;
				creq.strobe = dreq.strobe;
				creq.data = dreq.data;
				creq.len_last = '0;
				creq.burst = BURST_FIXED;
			end
			default: begin
				creq.is_write = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

	// bus widths
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 64;

	// byte offset inside a 64-bit word
	localparam int ALIGN_BITS = 3;
	// word index inside a line
	localparam int WORD_BITS = 3;
	localparam int WORDS_PER_LINE = 2 ** WORD_BITS;
	// byte offset inside a whole line
	localparam int OFFSET_BITS = ALIGN_BITS + WORD_BITS;

	localparam int INDEX_BITS = 4;
	localparam int NUM_LINES = 2 ** INDEX_BITS;

	// tag covers addr[27:10], the region nibble sits above it
	localparam int TAG_BITS = 28 - OFFSET_BITS - INDEX_BITS;

	// addr[31:28] value of the cacheable window
	localparam logic [3:0] CACHED_REGION = 4'h8;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [DATA_BITS-1:0] word_t;
	typedef logic [DATA_BITS/8-1:0] strobe_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [WORD_BITS-1:0] beat_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// transfer size, bytes = 2**code
	typedef enum logic [1:0] {
		MSIZE1,
		MSIZE2,
		MSIZE4,
		MSIZE8
	} msize_t;

	typedef enum logic {
		BURST_FIXED,
		BURST_INCR
	} burst_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITEBACK,
		S_FILL,
		S_UNCACHED
	} cache_state_t;

	// per-line metadata
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} line_meta_t;

	// cpu side, held until data_ok
	typedef struct packed {
		logic valid;
		addr_t addr;
		msize_t size;
		strobe_t strobe;
		word_t data;
	} dbus_req_t;

	typedef struct packed {
		logic data_ok;
		word_t data;
	} dbus_resp_t;

	// memory side, len_last is beats minus one
	typedef struct packed {
		logic valid;
		logic is_write;
		addr_t addr;
		msize_t size;
		strobe_t strobe;
		word_t data;
		beat_t len_last;
		burst_t burst;
	} cbus_req_t;

	typedef struct packed {
		logic ready;
		logic last;
		word_t data;
	} cbus_resp_t;

endpackage

//--- hw/line_store.sv
module line_store (
	input logic clk,
	input dcache_pkg::index_t index,
	input dcache_pkg::beat_t word_sel,
	input dcache_pkg::strobe_t wen,
	input dcache_pkg::word_t wdata,
	output dcache_pkg::word_t rdata
);
	import dcache_pkg::*;

	localparam int BYTES_PER_WORD = $bits(strobe_t);

	// flat word address, line index on top
	typedef logic [INDEX_BITS+WORD_BITS-1:0] waddr_t;

	word_t mem [NUM_LINES * WORDS_PER_LINE];
	waddr_t waddr;

	assign waddr = {index, word_sel};

	// combinational read, hits answer in the request cycle
	assign rdata = mem[waddr];

	// one enable per byte lane
	// fill uses all lanes, cpu writes use its strobe
	always_ff @(posedge clk) begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			if (wen[b]) begin
				mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

endmodule

//--- hw/tag_store.sv
module tag_store (
	input logic clk,
	input logic reset,
	input dcache_pkg::index_t index,
	input dcache_pkg::tag_t lookup_tag,
	input logic fill,
	input logic mark_dirty,
	output logic hit,
	output dcache_pkg::line_meta_t victim
);
	import dcache_pkg::*;

	// state bits, cleared on reset
	logic [NUM_LINES-1:0] valid_bits;
	logic [NUM_LINES-1:0] dirty_bits;
	// tag array
	tag_t tags [NUM_LINES];

	// current occupant of the indexed line
	assign victim.valid = valid_bits[index];
	assign victim.dirty = dirty_bits[index];
	assign victim.tag = tags[index];

	assign hit = victim.valid && (victim.tag == lookup_tag);

	// new line arrives clean
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0;
		end else if (mark_dirty) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	// tag written together with valid on fill
	always_ff @(posedge clk) begin
		if (fill) begin
			tags[index] <= lookup_tag;
		end
	end

endmodule

//--- tests/cbus_mem_model.sv
module cbus_mem_model (
	input logic clk,
	input logic reset,
	input dcache_pkg::cbus_req_t creq,
	output dcache_pkg::cbus_resp_t cresp
);
	timeunit 1ns;
	timeprecision 1ps;
	import dcache_pkg::*;

	// 32 KiB window, addr[14:3] picks the word
	localparam int MEM_WORDS = 4096;

	word_t mem [MEM_WORDS];
	beat_t beat;
	logic stall;
	logic [27:0] beat_addr;
	logic [11:0] widx;

	// each word holds its own byte address in both halves
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {2{32'(i) << 3}};
		end
	end

	// region nibble ignored, so 0x0xxxxxxx aliases 0x8xxxxxxx
	// incrementing bursts move one word per beat
	assign beat_addr = creq.addr[27:0]
		+ ((creq.burst == BURST_INCR) ? 28'({beat, 3'b000}) : 28'd0);
	assign widx = beat_addr[14:3];

	assign cresp.ready = creq.valid && !stall;
	assign cresp.last = beat == creq.len_last;
	assign cresp.data = mem[widx];

	always @(posedge clk) begin
		if (reset) begin
			beat <= '0;
			stall <= 1'b0;
		end else begin
			// back-pressure on about one cycle in four
			stall <= ($urandom % 4) == 0;
			if (cresp.ready) begin
				if (creq.is_write) begin
					for (int b = 0; b < 8; b++) begin
						if (creq.strobe[b]) begin
							mem[widx][b*8 +: 8] <= creq.data[b*8 +: 8];
						end
					end
				end
				// back to beat 0 once the burst is done
				beat <= cresp.last ? beat_t'(0) : beat + beat_t'(1);
			end
		end
	end

endmodule

//--- tests/dcache_checker.sv
module dcache_checker (
	input logic clk,
	input logic reset,
	input dcache_pkg::dbus_resp_t dresp,
	input dcache_pkg::cbus_req_t creq,
	input dcache_pkg::cbus_resp_t cresp
);
	timeunit 1ns;
	timeprecision 1ps;
	import dcache_pkg::*;

	// read back by the testbench at the end
	int unsigned failures = 0;

	// bus idle right after reset
	idle_after_reset: assert property (@(posedge clk) reset |=> !creq.valid)
		else begin
			failures++;
			$error("creq.valid high in the cycle after reset");
		end

	// request held while memory stalls, data and strobe may move
	held_under_stall: assert property (@(posedge clk) disable iff (reset)
		creq.valid && !cresp.ready |=> $stable({creq.valid, creq.is_write, creq.addr,
			creq.size, creq.len_last, creq.burst}))
		else begin
			failures++;
			$error("creq fields changed while stalled");
		end

	// line bursts start on a line boundary
	burst_aligned: assert property (@(posedge clk) disable iff (reset)
		creq.valid && creq.burst == BURST_INCR |-> creq.addr[OFFSET_BITS-1:0] == '0)
		else begin
			failures++;
			$error("burst address not line aligned");
		end

	// no cpu completion during writeback or fill
	quiet_in_burst: assert property (@(posedge clk) disable iff (reset)
		creq.valid && creq.burst == BURST_INCR |-> !dresp.data_ok)
		else begin
			failures++;
			$error("data_ok during a burst");
		end

endmodule

//--- tests/dcache_tb.sv
module dcache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import dcache_pkg::*;

	localparam int MEM_WORDS = 4096;
	localparam int CYCLES_PER_ROW = 40;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_RESET
	} op_t;

	// hit_now: data_ok expected in the request cycle
	typedef struct packed {
		op_t op;
		addr_t addr;
		strobe_t strobe;
		word_t data;
		logic hit_now;
	} row_t;

	logic clk;
	logic reset;
	dbus_req_t dreq;
	dbus_resp_t dresp;
	cbus_req_t creq;
	cbus_resp_t cresp;

	row_t rows [$];
	// what the cpu should see, same window as the memory model
	word_t shadow [MEM_WORDS];
	int cycles = 0;
	int cycle_limit = 0;

	dcache dcache_inst (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp),
		.creq(creq),
		.cresp(cresp)
	);

	cbus_mem_model mem_inst (
		.clk(clk),
		.reset(reset),
		.creq(creq),
		.cresp(cresp)
	);

	bind dcache dcache_checker checker_inst (
		.clk(clk),
		.reset(reset),
		.dresp(dresp),
		.creq(creq),
		.cresp(cresp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog, budget scales with the table length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "watchdog expired");
		end
	end

	// stop at the first bus assertion failure
	always @(negedge clk) begin
		if (dcache_inst.checker_inst.failures != 0) begin
			$display("bus assertion failed at %0t", $time);
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end
	end

	function automatic word_t merge_bytes(input word_t old, input word_t data,
		input strobe_t strobe);
		word_t result;
		result = old;
		for (int b = 0; b < 8; b++) begin
			if (strobe[b]) begin
				result[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return result;
	endfunction

	task automatic check_value(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s, got %h expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic void add_row(input op_t op, input addr_t addr, input strobe_t strobe,
		input word_t data, input logic hit_now);
		rows.push_back('{op, addr, strobe, data, hit_now});
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		dreq <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value(word_t'(dresp.data_ok), '0, "data_ok after reset");
	endtask

	// hold the request until data_ok, sampled mid-cycle
	task automatic run_request(input row_t row);
		int waited;
		int unsigned widx;
		word_t got;
		widx = row.addr[14:3];
		@(posedge clk);
		dreq <= '{valid: 1'b1, addr: row.addr, size: MSIZE8,
			strobe: row.strobe, data: row.data};
		waited = 0;
		@(negedge clk);
		while (!dresp.data_ok) begin
			waited++;
			@(negedge clk);
		end
		got = dresp.data;
		if (row.hit_now) begin
			check_value(word_t'(waited), '0, $sformatf("hit latency at %h", row.addr));
		end
		if (row.op == OP_WRITE) begin
			shadow[widx] = merge_bytes(shadow[widx], row.data, row.strobe);
		end else begin
			check_value(got, shadow[widx], $sformatf("read of %h", row.addr));
		end
		@(posedge clk);
		dreq <= '0;
	endtask

	task automatic build_table();
		// cold fill, then hits and partial writes in line 0x40
		add_row(OP_READ, 32'h8000_0048, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0070, 8'h00, 64'h0, 1'b1);
		add_row(OP_WRITE, 32'h8000_0050, 8'h0f, 64'h1111_2222_3333_4444, 1'b1);
		add_row(OP_READ, 32'h8000_0050, 8'h00, 64'h0, 1'b1);
		add_row(OP_WRITE, 32'h8000_0050, 8'h30, 64'haaaa_bbbb_cccc_dddd, 1'b1);
		add_row(OP_READ, 32'h8000_0050, 8'h00, 64'h0, 1'b1);
		// same index, new tag, dirty victim goes out
		add_row(OP_READ, 32'h8000_0440, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h0000_0050, 8'h00, 64'h0, 1'b0);
		// uncached writes, then their cached aliases
		add_row(OP_WRITE, 32'h0000_0100, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0);
		add_row(OP_WRITE, 32'h0000_0108, 8'h0f, 64'hfedc_ba98_7654_3210, 1'b0);
		add_row(OP_READ, 32'h0000_0108, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0100, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0108, 8'h00, 64'h0, 1'b1);
		add_row(OP_WRITE, 32'h8000_0448, 8'hff, 64'h5a5a_5a5a_a5a5_a5a5, 1'b1);
		add_row(OP_READ, 32'h8000_0048, 8'h00, 64'h0, 1'b0);
		// write miss, then evict it before reset
		add_row(OP_WRITE, 32'h8000_0200, 8'h3c, 64'h0f0f_f0f0_3c3c_c3c3, 1'b0);
		add_row(OP_READ, 32'h8000_0600, 8'h00, 64'h0, 1'b0);
		add_row(OP_RESET, 32'h0, 8'h00, 64'h0, 1'b0);
		// everything must come back from memory
		add_row(OP_READ, 32'h8000_0050, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0448, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0200, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0108, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0300, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h8000_0058, 8'h00, 64'h0, 1'b0);
		add_row(OP_READ, 32'h0000_0448, 8'h00, 64'h0, 1'b0);
	endtask

	initial begin
		void'($urandom(18));
		reset = 1'b1;
		dreq = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = {2{32'(i) << 3}};
		end
		build_table();
		cycle_limit = rows.size() * CYCLES_PER_ROW;
		apply_reset();
		foreach (rows[i]) begin
			if (rows[i].op == OP_RESET) begin
				apply_reset();
			end else begin
				run_request(rows[i]);
			end
		end
		repeat (2) @(posedge clk);
		if (dcache_inst.checker_inst.failures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("bus assertions failed %0d times", dcache_inst.checker_inst.failures);
			$display("Simulation failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule
